// ==== build.f ====
verilog/bk_bus_pkg.sv
verilog/bk_audio_pkg.sv
verilog/bk_cpu_clock_enable.sv
verilog/bk_bus_responder.sv
verilog/bk_system_register.sv
verilog/bk_parallel_port.sv
verilog/bk_vector_irq.sv
verilog/bk_audio_mixer.sv
verilog/bk_glue_top.sv
testbench/tb_clock_gen.sv
testbench/bk_glue_assert.sv
testbench/tb_bk_glue.sv

// ==== testbench/bk_glue_assert.sv ====
`timescale 1ns/1ns

module bk_glue_assert import bk_bus_pkg::*; (
	input logic  clk_sys,
	input logic  rst_i,
	input logic  bus_stb_i,
	input logic  bus_ack_o,
	input word_t bus_rdata_o
);

	int fail_count = 0;

	// Reply drops only once the master has let go
	ack_falls_after_stb: assert property (@(posedge clk_sys) disable iff (rst_i)
		$fell(bus_ack_o) |-> !$past(bus_stb_i))
	else begin
		$error("bus_ack_o fell while bus_stb_i was still high");
		fail_count++;
	end

	// No reply without a cycle
	ack_needs_stb: assert property (@(posedge clk_sys) disable iff (rst_i)
		$rose(bus_ack_o) |-> $past(bus_stb_i))
	else begin
		$error("bus_ack_o rose without bus_stb_i");
		fail_count++;
	end

	// Read bus idles at zero
	rdata_idle_zero: assert property (@(posedge clk_sys) disable iff (rst_i)
		!bus_ack_o |-> (bus_rdata_o == '0))
	else begin
		$error("bus_rdata_o not zero while bus_ack_o is low");
		fail_count++;
	end

endmodule

bind bk_bus_responder bk_glue_assert u_assert (
	.clk_sys     (clk_sys),
	.rst_i       (rst_i),
	.bus_stb_i   (bus_stb_i),
	.bus_ack_o   (bus_ack_o),
	.bus_rdata_o (bus_rdata_o)
);

// ==== testbench/tb_bk_glue.sv ====
`timescale 1ns/1ns

module tb_bk_glue import bk_bus_pkg::*, bk_audio_pkg::*; ();

	// About 40 bus cycles of at most 50 clocks, plus margin
	localparam int max_cycles = 4000;

	logic       clk_sys;
	logic       rst;
	word_t      bus_addr;
	word_t      bus_wdata;
	word_t      bus_rdata;
	wtbt_t      bus_wtbt;
	logic       bus_we;
	logic       bus_stb;
	logic       bus_sync;
	logic       bus_iacko;
	logic       bus_ack;
	logic       virq;
	logic       model_bk0010;
	logic       turbo;
	logic       covox_en;
	logic       key_down;
	logic [7:0] joystick;
	logic       irq60_req;
	logic       irq274_req;
	sample_t    sample_left;
	sample_t    sample_right;

	// Model state and bookkeeping
	spk_t        spk_m;
	word_t       covox_m;
	logic [31:0] rng;
	int          errors;
	int          checks;
	int          cycles;
	int          test_num;
	int          test_errs;

	string   word_name_q[$];
	word_t   word_got_q[$];
	word_t   word_exp_q[$];
	string   smp_name_q[$];
	sample_t smp_got_q[$];
	sample_t smp_exp_q[$];

	tb_clock_gen u_clk (
		.clk_sys (clk_sys),
		.rst_o   (rst)
	);

	bk_glue_top u_dut (
		.clk_sys        (clk_sys),
		.rst_i          (rst),
		.bus_addr_i     (bus_addr),
		.bus_wdata_i    (bus_wdata),
		.bus_we_i       (bus_we),
		.bus_wtbt_i     (bus_wtbt),
		.bus_stb_i      (bus_stb),
		.bus_sync_i     (bus_sync),
		.bus_iacko_i    (bus_iacko),
		.bus_rdata_o    (bus_rdata),
		.bus_ack_o      (bus_ack),
		.virq_o         (virq),
		.model_bk0010_i (model_bk0010),
		.turbo_i        (turbo),
		.covox_en_i     (covox_en),
		.key_down_i     (key_down),
		.joystick_i     (joystick),
		.irq60_req_i    (irq60_req),
		.irq274_req_i   (irq274_req),
		.sample_left_o  (sample_left),
		.sample_right_o (sample_right)
	);

	////////////////////////////////////////
	// Reference model

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic word_t sysreg_ref(input logic key, input logic super_flag);
		return {start_addr_c, 1'b1, ~key, 3'b000, super_flag, 2'b00};
	endfunction

	function automatic word_t port_ref(input logic [7:0] joy);
		return {8'h00, joy};
	endfunction

	// Speaker alone, or Covox byte widened to 11 bits plus speaker
	function automatic sample_t sample_ref(input logic cov_en, input spk_t spk,
		input logic [7:0] chan);
		if (!cov_en)
			return {spk, 9'b0};
		return {1'b0, chan, chan[7:5]} + {4'b0000, spk, 5'b00000};
	endfunction

	////////////////////////////////////////
	// Compare

	task automatic check_word(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_sample(input string name, input sample_t got, input sample_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	always @(posedge clk_sys) begin
		while (word_got_q.size() > 0)
			check_word(word_name_q.pop_front(), word_got_q.pop_front(), word_exp_q.pop_front());
		while (smp_got_q.size() > 0)
			check_sample(smp_name_q.pop_front(), smp_got_q.pop_front(), smp_exp_q.pop_front());
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("Timeout: the tests did not finish within %0d cycles", max_cycles);
			$display("Done: errors found");
			$finish;
		end
	end

	////////////////////////////////////////
	// Stimulus helpers

	task automatic expect_word(input string name, input word_t got, input word_t exp);
		word_name_q.push_back(name);
		word_got_q.push_back(got);
		word_exp_q.push_back(exp);
	endtask

	task automatic expect_samples();
		smp_name_q.push_back("sample_left_o");
		smp_got_q.push_back(sample_left);
		smp_exp_q.push_back(sample_ref(covox_en, spk_m, covox_m[7:0]));
		smp_name_q.push_back("sample_right_o");
		smp_got_q.push_back(sample_right);
		smp_exp_q.push_back(sample_ref(covox_en, spk_m, covox_m[15:8]));
	endtask

	// Starts on a CPU enable, so the access edge never meets the reply enable
	task automatic bus_cycle(input word_t addr, input word_t data, input logic we,
		input wtbt_t wtbt, input logic iack, output word_t rdata);
		do @(posedge clk_sys); while (!u_dut.ce_cpu);
		bus_addr  <= addr;
		bus_wdata <= data;
		bus_we    <= we;
		bus_wtbt  <= wtbt;
		bus_iacko <= iack;
		bus_stb   <= 1'b1;
		bus_sync  <= 1'b1;
		do @(posedge clk_sys); while (!bus_ack);
		rdata = bus_rdata;
		bus_stb   <= 1'b0;
		bus_sync  <= 1'b0;
		bus_we    <= 1'b0;
		bus_wtbt  <= 2'b00;
		bus_iacko <= 1'b0;
	endtask

	task automatic end_test(input string name);
		repeat (2) @(posedge clk_sys);
		$display("test %0d %s: %0d errors", test_num, name, errors - test_errs);
		test_num++;
		test_errs = errors;
	endtask

	////////////////////////////////////////
	// Tests

	initial begin
		word_t rd;
		word_t data;
		wtbt_t wtbt;
		logic  m;
		int    asrt;
		bus_addr     = '0;
		bus_wdata    = '0;
		bus_wtbt     = 2'b00;
		bus_we       = 1'b0;
		bus_stb      = 1'b0;
		bus_sync     = 1'b0;
		bus_iacko    = 1'b0;
		model_bk0010 = 1'b0;
		turbo        = 1'b0;
		covox_en     = 1'b0;
		key_down     = 1'b0;
		joystick     = 8'h00;
		irq60_req    = 1'b0;
		irq274_req   = 1'b0;
		spk_m        = '0;
		covox_m      = '0;
		rng          = 32'd25546;
		errors       = 0;
		checks       = 0;
		cycles       = 0;
		test_num     = 1;
		test_errs    = 0;
		wait (rst === 1'b0);
		@(posedge clk_sys);
		expect_samples();

		// Flag shows the direction of the latest access
		bus_cycle(sysreg_addr_c, 16'h0000, 1'b0, 2'b00, 1'b0, rd);
		expect_word("bus_rdata_o", rd, sysreg_ref(1'b0, 1'b0));
		bus_cycle(sysreg_addr_c, 16'h0000, 1'b1, 2'b00, 1'b0, rd);
		expect_word("bus_rdata_o", rd, sysreg_ref(1'b0, 1'b1));
		key_down <= 1'b1;
		bus_cycle(sysreg_addr_c, 16'h0000, 1'b0, 2'b00, 1'b0, rd);
		expect_word("bus_rdata_o", rd, sysreg_ref(1'b1, 1'b0));
		key_down <= 1'b0;
		end_test("system register");

		for (int i = 0; i < 12; i++) begin
			rng  = lcg_step(rng);
			data = rng[31:16];
			wtbt = rng[9:8];
			m    = rng[12];
			model_bk0010 <= m;
			bus_cycle(sysreg_addr_c, data, 1'b1, wtbt, 1'b0, rd);
			if (wtbt[0] && (!wtbt[1] || !data[11]))
				spk_m = {data[6], data[5], data[2] & ~m};
			expect_samples();
		end
		model_bk0010 <= 1'b0;
		end_test("speaker bits");

		covox_en <= 1'b1;
		repeat (2) @(posedge clk_sys);
		expect_samples();
		for (int i = 0; i < 8; i++) begin
			rng  = lcg_step(rng);
			data = rng[31:16];
			wtbt = rng[9:8];
			bus_cycle(port_addr_c, data, 1'b1, wtbt, 1'b0, rd);
			if (wtbt[0])
				covox_m[7:0] = data[7:0];
			if (wtbt[1])
				covox_m[15:8] = data[15:8];
			expect_samples();
		end
		// Writes with Covox off must not reach the latch
		covox_en <= 1'b0;
		repeat (2) @(posedge clk_sys);
		expect_samples();
		for (int i = 0; i < 3; i++) begin
			rng = lcg_step(rng);
			bus_cycle(port_addr_c, rng[31:16], 1'b1, 2'b11, 1'b0, rd);
			expect_samples();
		end
		covox_en <= 1'b1;
		repeat (2) @(posedge clk_sys);
		expect_samples();
		covox_en <= 1'b0;
		end_test("covox");

		for (int i = 0; i < 2; i++) begin
			rng = lcg_step(rng);
			joystick <= rng[23:16];
			bus_cycle(port_addr_c, 16'h0000, 1'b0, 2'b00, 1'b0, rd);
			expect_word("bus_rdata_o", rd, port_ref(rng[23:16]));
		end
		end_test("joystick");

		expect_word("virq_o", {15'b0, virq}, 16'h0000);
		irq274_req <= 1'b1;
		@(posedge clk_sys);
		irq274_req <= 1'b0;
		irq60_req  <= 1'b1;
		@(posedge clk_sys);
		irq60_req <= 1'b0;
		@(posedge clk_sys);
		expect_word("virq_o", {15'b0, virq}, 16'h0001);
		bus_cycle(16'h0000, 16'h0000, 1'b0, 2'b00, 1'b1, rd);
		expect_word("bus_rdata_o", rd, vec60_c);
		bus_cycle(16'h0000, 16'h0000, 1'b0, 2'b00, 1'b1, rd);
		expect_word("bus_rdata_o", rd, vec274_c);
		expect_word("virq_o", {15'b0, virq}, 16'h0000);
		end_test("interrupts");

		for (int i = 0; i < 4; i++) begin
			rng = lcg_step(rng);
			model_bk0010 <= i[1];
			turbo        <= i[0];
			key_down     <= i[0];
			joystick     <= rng[23:16];
			bus_cycle(sysreg_addr_c, 16'h0000, 1'b0, 2'b00, 1'b0, rd);
			expect_word("bus_rdata_o", rd, sysreg_ref(i[0], 1'b0));
			bus_cycle(port_addr_c, 16'h0000, 1'b0, 2'b00, 1'b0, rd);
			expect_word("bus_rdata_o", rd, port_ref(rng[23:16]));
		end
		end_test("turbo and model");

		asrt = u_dut.u_responder.u_assert.fail_count;
		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors, asrt);
		if (errors == 0 && asrt == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
	output logic clk_sys,
	output logic rst_o
);

	// 20 ns period
	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// Reset held over the first eight rising edges
	initial begin
		rst_o = 1'b1;
		repeat (8) @(posedge clk_sys);
		rst_o <= 1'b0;
	end

endmodule

// ==== verilog/bk_audio_mixer.sv ====
`timescale 1ns/1ns

module bk_audio_mixer import bk_bus_pkg::*, bk_audio_pkg::*; (
	input  logic    clk_sys,
	input  logic    rst_i,
	input  logic    covox_en_i,
	input  spk_t    spk_i,
	input  word_t   covox_i,
	output sample_t sample_left_o,
	output sample_t sample_right_o
);

	sample_t spk_mix;
	sample_t left_mix;
	sample_t right_mix;

	// Speaker under the Covox byte
	assign spk_mix = {4'b0000, spk_i, 5'b00000};

	// Byte widened to 11 bits by repeating its top bits
	assign left_mix  = {1'b0, covox_i[7:0], covox_i[7:5]} + spk_mix;
	assign right_mix = {1'b0, covox_i[15:8], covox_i[15:13]} + spk_mix;

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			sample_left_o  <= '0;
			sample_right_o <= '0;
		end else if (covox_en_i) begin
			sample_left_o  <= left_mix;
			sample_right_o <= right_mix;
		end else begin
			// Speaker alone at full scale
			sample_left_o  <= {spk_i, 9'b0};
			sample_right_o <= {spk_i, 9'b0};
		end
	end

endmodule

// ==== verilog/bk_audio_pkg.sv ====
package bk_audio_pkg;

	//////////////////// Audio ////////////////////

	// One mixed audio sample per channel
	typedef logic [11:0] sample_t;

	//////////////////// CPU clock divider ////////////////////

	// Base divide count, BK0011M at normal speed
	localparam logic [4:0] cpu_div_base_c = 5'd23;

	// Extra count for the slower BK0010
	localparam logic [4:0] cpu_div_bk0010_c = 5'd8;

	// Turbo halves the whole count by a right shift
	// Period is count + 1 clocks, so
	//   BK0011M      24 or 12 clocks
	//   BK0010       32 or 16 clocks
	// Largest count is 31 and fits five bits

endpackage

// ==== verilog/bk_bus_pkg.sv ====
package bk_bus_pkg;

	//////////////////// Bus types ////////////////////

	// One bus word and its byte-lane write strobes
	typedef logic [15:0] word_t;
	typedef logic [1:0]  wtbt_t;

	// Interrupt vector as presented in an acknowledge cycle
	typedef logic [15:0] vector_t;

	// Speaker bits of the system register, MSB first
	typedef logic [2:0]  spk_t;

	/////////////////// Peer addresses ///////////////////

	// System register
	localparam word_t sysreg_addr_c = 16'o177716;

	// Parallel port, also the Covox latch
	localparam word_t port_addr_c = 16'o177714;

	/////////////////// Vectors ///////////////////

	// 060 wins over 274 when both are pending
	localparam vector_t vec60_c  = 16'o000060;
	localparam vector_t vec274_c = 16'o000274;

	// High byte of the system register read word
	localparam logic [7:0] start_addr_c = 8'h80;

endpackage

// ==== verilog/bk_bus_responder.sv ====
`timescale 1ns/1ns

module bk_bus_responder import bk_bus_pkg::*; (
	input  logic  clk_sys,
	input  logic  rst_i,
	input  logic  ce_cpu_i,
	input  word_t bus_addr_i,
	input  logic  bus_stb_i,
	input  logic  bus_we_i,
	input  logic  bus_iacko_i,
	output logic  sysreg_sel_o,
	output logic  port_sel_o,
	output logic  ivec_sel_o,
	input  word_t sysreg_rdata_i,
	input  word_t port_rdata_i,
	input  word_t ivec_rdata_i,
	input  logic  ivec_ack_i,
	output word_t bus_rdata_o,
	output logic  bus_ack_o
);

	word_t merged_rdata;
	logic  reply;
	word_t rdata_q;
	logic  ack_q;

	//////////////// Decode ////////////////

	// Address decode is meaningless during a vector fetch
	assign sysreg_sel_o = ~bus_iacko_i & (bus_addr_i == sysreg_addr_c);
	assign port_sel_o   = ~bus_iacko_i & (bus_addr_i == port_addr_c);
	assign ivec_sel_o   = bus_iacko_i & ~bus_we_i;

	//////////////// Read merge ////////////////

	// Unselected peers drive zero
	assign merged_rdata = sysreg_rdata_i | port_rdata_i | ivec_rdata_i;

	// Registers reply at once, a vector fetch waits for the controller
	assign reply = bus_stb_i & (sysreg_sel_o | port_sel_o | (ivec_sel_o & ivec_ack_i));

	//////////////// Reply ////////////////

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			ack_q   <= 1'b0;
			rdata_q <= '0;
		end else if (ce_cpu_i) begin
			ack_q   <= reply;
			// Data only alongside the reply
			rdata_q <= reply ? merged_rdata : '0;
		end
	end

	assign bus_ack_o   = ack_q;
	assign bus_rdata_o = rdata_q;

endmodule

// ==== verilog/bk_cpu_clock_enable.sv ====
`timescale 1ns/1ns

module bk_cpu_clock_enable import bk_audio_pkg::*; (
	input  logic clk_sys,
	input  logic rst_i,
	input  logic model_bk0010_i,
	input  logic turbo_i,
	input  logic bus_sync_i,
	output logic ce_cpu_o
);

	logic [4:0] cnt_q;
	logic [4:0] div_count;
	logic       turbo_q;
	logic       turbo_nxt;

	// Turbo may only move between bus cycles
	assign turbo_nxt = bus_sync_i ? turbo_q : turbo_i;

	// Count for the period that starts at this reload
	assign div_count = (cpu_div_base_c + (model_bk0010_i ? cpu_div_bk0010_c : 5'd0))
		>> turbo_nxt;

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			cnt_q   <= 5'd0;
			turbo_q <= 1'b0;
		end else if (cnt_q == 5'd0) begin
			// End of period, reload and resample turbo
			cnt_q   <= div_count;
			turbo_q <= turbo_nxt;
		end else begin
			cnt_q <= cnt_q - 5'd1;
		end
	end

	// One clock wide, once per period
	assign ce_cpu_o = (cnt_q == 5'd0);

endmodule

// ==== verilog/bk_glue_top.sv ====
`timescale 1ns/1ns

module bk_glue_top import bk_bus_pkg::*, bk_audio_pkg::*; (
	input  logic    clk_sys,
	input  logic    rst_i,
	// Bus master side
	input  word_t   bus_addr_i,
	input  word_t   bus_wdata_i,
	input  logic    bus_we_i,
	input  wtbt_t   bus_wtbt_i,
	input  logic    bus_stb_i,
	input  logic    bus_sync_i,
	input  logic    bus_iacko_i,
	output word_t   bus_rdata_o,
	output logic    bus_ack_o,
	output logic    virq_o,
	// Machine configuration and inputs
	input  logic    model_bk0010_i,
	input  logic    turbo_i,
	input  logic    covox_en_i,
	input  logic    key_down_i,
	input  logic [7:0] joystick_i,
	input  logic    irq60_req_i,
	input  logic    irq274_req_i,
	// Audio
	output sample_t sample_left_o,
	output sample_t sample_right_o
);

	logic  ce_cpu;
	logic  sysreg_sel;
	logic  port_sel;
	logic  ivec_sel;
	logic  ivec_ack;
	word_t sysreg_rdata;
	word_t port_rdata;
	word_t ivec_rdata;
	spk_t  spk;
	word_t covox;

	bk_cpu_clock_enable u_clock_enable (
		.clk_sys        (clk_sys),
		.rst_i          (rst_i),
		.model_bk0010_i (model_bk0010_i),
		.turbo_i        (turbo_i),
		.bus_sync_i     (bus_sync_i),
		.ce_cpu_o       (ce_cpu)
	);

	bk_bus_responder u_responder (
		.clk_sys        (clk_sys),
		.rst_i          (rst_i),
		.ce_cpu_i       (ce_cpu),
		.bus_addr_i     (bus_addr_i),
		.bus_stb_i      (bus_stb_i),
		.bus_we_i       (bus_we_i),
		.bus_iacko_i    (bus_iacko_i),
		.sysreg_sel_o   (sysreg_sel),
		.port_sel_o     (port_sel),
		.ivec_sel_o     (ivec_sel),
		.sysreg_rdata_i (sysreg_rdata),
		.port_rdata_i   (port_rdata),
		.ivec_rdata_i   (ivec_rdata),
		.ivec_ack_i     (ivec_ack),
		.bus_rdata_o    (bus_rdata_o),
		.bus_ack_o      (bus_ack_o)
	);

	bk_system_register u_sysreg (
		.clk_sys        (clk_sys),
		.rst_i          (rst_i),
		.sel_i          (sysreg_sel),
		.bus_stb_i      (bus_stb_i),
		.bus_we_i       (bus_we_i),
		.bus_wtbt_i     (bus_wtbt_i),
		.bus_wdata_i    (bus_wdata_i),
		.key_down_i     (key_down_i),
		.model_bk0010_i (model_bk0010_i),
		.rdata_o        (sysreg_rdata),
		.spk_o          (spk)
	);

	bk_parallel_port u_port (
		.clk_sys     (clk_sys),
		.rst_i       (rst_i),
		.sel_i       (port_sel),
		.bus_stb_i   (bus_stb_i),
		.bus_we_i    (bus_we_i),
		.bus_wtbt_i  (bus_wtbt_i),
		.bus_wdata_i (bus_wdata_i),
		.covox_en_i  (covox_en_i),
		.joystick_i  (joystick_i),
		.rdata_o     (port_rdata),
		.covox_o     (covox)
	);

	bk_vector_irq u_vic (
		.clk_sys      (clk_sys),
		.rst_i        (rst_i),
		.ce_cpu_i     (ce_cpu),
		.irq60_req_i  (irq60_req_i),
		.irq274_req_i (irq274_req_i),
		.sel_i        (ivec_sel),
		.bus_stb_i    (bus_stb_i),
		.virq_o       (virq_o),
		.rdata_o      (ivec_rdata),
		.ack_o        (ivec_ack)
	);

	bk_audio_mixer u_mixer (
		.clk_sys        (clk_sys),
		.rst_i          (rst_i),
		.covox_en_i     (covox_en_i),
		.spk_i          (spk),
		.covox_i        (covox),
		.sample_left_o  (sample_left_o),
		.sample_right_o (sample_right_o)
	);

endmodule

// ==== verilog/bk_parallel_port.sv ====
`timescale 1ns/1ns

module bk_parallel_port import bk_bus_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_i,
	input  logic       sel_i,
	input  logic       bus_stb_i,
	input  logic       bus_we_i,
	input  wtbt_t      bus_wtbt_i,
	input  word_t      bus_wdata_i,
	input  logic       covox_en_i,
	input  logic [7:0] joystick_i,
	output word_t      rdata_o,
	output word_t      covox_o
);

	logic  wr;
	logic  wr_q;
	word_t latch_q;

	// Without Covox these writes belong to the sound chip
	assign wr = sel_i & bus_stb_i & bus_we_i & covox_en_i;

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			wr_q    <= 1'b0;
			latch_q <= '0;
		end else begin
			wr_q <= wr;
			if (wr & ~wr_q) begin
				if (bus_wtbt_i[0]) latch_q[7:0]  <= bus_wdata_i[7:0];
				if (bus_wtbt_i[1]) latch_q[15:8] <= bus_wdata_i[15:8];
			end
		end
	end

	assign covox_o = latch_q;

	// Joystick in the low byte
	assign rdata_o = sel_i ? {8'h00, joystick_i} : '0;

endmodule

// ==== verilog/bk_system_register.sv ====
`timescale 1ns/1ns

module bk_system_register import bk_bus_pkg::*; (
	input  logic  clk_sys,
	input  logic  rst_i,
	input  logic  sel_i,
	input  logic  bus_stb_i,
	input  logic  bus_we_i,
	input  wtbt_t bus_wtbt_i,
	input  word_t bus_wdata_i,
	input  logic  key_down_i,
	input  logic  model_bk0010_i,
	output word_t rdata_o,
	output spk_t  spk_o
);

	logic acc;
	logic acc_q;
	logic new_acc;
	logic spk_write;
	logic super_q;
	spk_t spk_q;

	// Access edge, so each bus cycle counts once
	assign acc     = sel_i & bus_stb_i;
	assign new_acc = acc & ~acc_q;

	// Low lane carries the speaker bits
	// High lane with bit 11 set is a different function
	assign spk_write = bus_we_i & bus_wtbt_i[0] &
		(~bus_wtbt_i[1] | ~bus_wdata_i[11]);

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			acc_q   <= 1'b0;
			super_q <= 1'b0;
			spk_q   <= '0;
		end else begin
			acc_q <= acc;
			if (new_acc) begin
				// Last access direction
				super_q <= bus_we_i;
				if (spk_write) begin
					// No tape out bit on BK0010
					spk_q <= {bus_wdata_i[6], bus_wdata_i[5],
						bus_wdata_i[2] & ~model_bk0010_i};
				end
			end
		end
	end

	//////////////// Read word ////////////////

	assign rdata_o = sel_i
		? {start_addr_c, 1'b1, ~key_down_i, 3'b000, super_q, 2'b00}
		: '0;

	assign spk_o = spk_q;

endmodule

// ==== verilog/bk_vector_irq.sv ====
`timescale 1ns/1ns

module bk_vector_irq import bk_bus_pkg::*; (
	input  logic  clk_sys,
	input  logic  rst_i,
	input  logic  ce_cpu_i,
	input  logic  irq60_req_i,
	input  logic  irq274_req_i,
	input  logic  sel_i,
	input  logic  bus_stb_i,
	output logic  virq_o,
	output word_t rdata_o,
	output logic  ack_o
);

	logic [1:0] pend_q;
	logic [1:0] take;
	logic       grant;
	logic       ack_q;
	vector_t    vec_q;

	// Once per acknowledge cycle, on the CPU enable
	assign grant = ce_cpu_i & sel_i & bus_stb_i & ~ack_q;

	// Bit 0 is 060 and wins
	assign take[0] = grant & pend_q[0];
	assign take[1] = grant & ~pend_q[0] & pend_q[1];

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			pend_q <= 2'b00;
			ack_q  <= 1'b0;
		end else begin
			// A new pulse is never lost to a clear
			pend_q <= (pend_q & ~take) | {irq274_req_i, irq60_req_i};
			if (|take) ack_q <= 1'b1;
			else if (~bus_stb_i) ack_q <= 1'b0;
		end
	end

	// Vector held for the rest of the cycle
	always_ff @(posedge clk_sys) begin
		if (take[0]) vec_q <= vec60_c;
		else if (take[1]) vec_q <= vec274_c;
	end

	assign virq_o  = |pend_q;
	assign ack_o   = ack_q;
	assign rdata_o = sel_i ? vec_q : '0;

endmodule
